//--- hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural registers
`define CORE_NREGS 32

// First fetch address
`define CORE_RESET_PC 32'h0000_0000

// Memory depths in words
`define CORE_IMEM_WORDS 256
`define CORE_DMEM_WORDS 64

`endif

//--- hdl/core_isa_pkg.sv
`include "core_consts.svh"

package core_isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC_PLUS4
    } wb_sel_e;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        word_t     imm;
        alu_op_e   alu_op;
        wb_sel_e   wb_sel;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      is_halt;
    } decoded_instr_t;

endpackage

//--- hdl/core_bus_pkg.sv
`include "core_consts.svh"

package core_bus_pkg;

    import core_isa_pkg::*;

    // Word addresses, byte offset dropped
    typedef logic [`CORE_XLEN-3:0] word_addr_t;

    typedef struct packed {
        word_addr_t addr;
    } imem_req_t;

    typedef struct packed {
        word_addr_t addr;
        word_t      wdata;
        logic       we;
    } dmem_req_t;

    // One record per completed instruction
    typedef struct packed {
        word_t     pc;
        word_t     instr;
        reg_addr_t rd;
        word_t     rd_value;
        logic      reg_write;
    } retire_t;

endpackage

//--- hdl/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
    input  logic clk,
    input  logic reset_i,
    input  logic is_halt_i,
    input  logic mem_read_i,
    input  logic mem_write_i,
    output logic fetch_req_o,
    output logic decode_load_o,
    output logic exec_load_o,
    output logic mem_req_o,
    output logic wb_commit_o,
    output logic halted_o
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALTED
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   halted_q;

    always_comb begin
        case (state_q)
            S_FETCH:     state_d = S_DECODE;
            S_DECODE:    state_d = S_EXECUTE;
            // Only loads and stores spend a cycle on the data port
            S_EXECUTE:   state_d = (mem_read_i || mem_write_i) ? S_MEMORY : S_WRITEBACK;
            S_MEMORY:    state_d = S_WRITEBACK;
            S_WRITEBACK: state_d = is_halt_i ? S_HALTED : S_FETCH;
            S_HALTED:    state_d = S_HALTED;
            default:     state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= S_FETCH;
            halted_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            halted_q <= (state_q == S_HALTED);
        end
    end

    assign fetch_req_o   = (state_q == S_FETCH);
    assign decode_load_o = (state_q == S_DECODE);
    assign exec_load_o   = (state_q == S_EXECUTE);
    assign mem_req_o     = (state_q == S_MEMORY);
    assign wb_commit_o   = (state_q == S_WRITEBACK);
    assign halted_o      = halted_q;

    // Decoded flags must hold steady through the data cycle
    a_mem_for_access: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o |-> (mem_read_i || mem_write_i));

endmodule

//--- hdl/core_fetch.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_fetch import core_isa_pkg::*, core_bus_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      fetch_req_i,
    input  logic      wb_commit_i,
    input  logic      branch_taken_i,
    input  word_t     target_i,
    input  logic      is_jal_i,
    output imem_req_t imem_req_o,
    output logic      imem_req_valid_o,
    output word_t     pc_o
);

    word_t pc_q;
    word_t pc_next;

    // Redirect on taken branch or jump, else fall through
    assign pc_next = (branch_taken_i || is_jal_i) ? target_i : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (wb_commit_i) begin
            pc_q <= pc_next;
        end
    end

    assign imem_req_o.addr  = pc_q[`CORE_XLEN-1:2];
    assign imem_req_valid_o = fetch_req_i;
    assign pc_o             = pc_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

//--- hdl/core_decode.sv
`timescale 1ns/1ps

module core_decode import core_isa_pkg::*; (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           decode_load_i,
    input  word_t          imem_rdata_i,
    input  word_t          pc_i,
    input  word_t          rs1_data_i,
    input  word_t          rs2_data_i,
    output reg_addr_t      rs1_addr_o,
    output reg_addr_t      rs2_addr_o,
    output decoded_instr_t decoded_o,
    output word_t          instr_o
);

    logic [6:0]     opc;
    logic [2:0]     funct3;
    reg_addr_t      rd;
    word_t          imm_i;
    word_t          imm_s;
    word_t          imm_b;
    word_t          imm_u;
    word_t          imm_j;
    alu_op_e        alu_fn;
    decoded_instr_t dec;
    decoded_instr_t decoded_q;
    word_t          instr_q;

    assign opc        = imem_rdata_i[6:0];
    assign funct3     = imem_rdata_i[14:12];
    assign rd         = imem_rdata_i[11:7];
    assign rs1_addr_o = imem_rdata_i[19:15];
    assign rs2_addr_o = imem_rdata_i[24:20];

    // Immediate formats
    assign imm_i = {{20{imem_rdata_i[31]}}, imem_rdata_i[31:20]};
    assign imm_s = {{20{imem_rdata_i[31]}}, imem_rdata_i[31:25], imem_rdata_i[11:7]};
    assign imm_b = {{19{imem_rdata_i[31]}}, imem_rdata_i[31], imem_rdata_i[7],
                    imem_rdata_i[30:25], imem_rdata_i[11:8], 1'b0};
    assign imm_u = {imem_rdata_i[31:12], 12'b0};
    assign imm_j = {{11{imem_rdata_i[31]}}, imem_rdata_i[31], imem_rdata_i[19:12],
                    imem_rdata_i[20], imem_rdata_i[30:21], 1'b0};

    // SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opc == OPC_OP && imem_rdata_i[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_fn = ALU_SLT;
            3'b100:  alu_fn = ALU_XOR;
            3'b110:  alu_fn = ALU_OR;
            3'b111:  alu_fn = ALU_AND;
            default: alu_fn = ALU_ADD;
        endcase
    end

    always_comb begin
        dec            = '0;
        dec.pc         = pc_i;
        dec.rd         = rd;
        dec.op_a       = rs1_data_i;
        dec.op_b       = rs2_data_i;
        dec.store_data = rs2_data_i;
        dec.alu_op     = ALU_ADD;
        dec.wb_sel     = WB_ALU;
        case (opc)
            OPC_OP: begin
                dec.alu_op    = alu_fn;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.imm       = imm_i;
                dec.op_b      = imm_i;
                dec.alu_op    = alu_fn;
                dec.reg_write = 1'b1;
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.op_b      = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.imm       = imm_i;
                dec.op_b      = imm_i;
                dec.wb_sel    = WB_LOAD;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_STORE: begin
                dec.imm       = imm_s;
                dec.op_b      = imm_s;
                dec.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.wb_sel    = WB_PC_PLUS4;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_SYSTEM: dec.is_halt = 1'b1;
            default: ;
        endcase
        // x0 as destination means no write at all
        if (rd == '0) begin
            dec.reg_write = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            decoded_q <= '0;
        end else if (decode_load_i) begin
            decoded_q <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_load_i) begin
            instr_q <= imem_rdata_i;
        end
    end

    assign decoded_o = decoded_q;
    assign instr_o   = instr_q;

    a_known_opcode: assert property (@(posedge clk) disable iff (reset_i)
        decode_load_i |-> opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD,
                                      OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_SYSTEM});

endmodule

//--- hdl/core_regfile.sv
`timescale 1ns/1ps

module core_regfile #(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [ADDR_WIDTH-1:0] raddr1_i,
    input  logic [ADDR_WIDTH-1:0] raddr2_i,
    output logic [DATA_WIDTH-1:0] rdata1_o,
    output logic [DATA_WIDTH-1:0] rdata2_o
);

    logic [DATA_WIDTH-1:0] regs [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Entry 0 is never written, so force its read value
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- hdl/core_exec.sv
`timescale 1ns/1ps

module core_exec import core_isa_pkg::*; (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           exec_load_i,
    input  decoded_instr_t decoded_i,
    output word_t          alu_result_o,
    output logic           branch_taken_o,
    output word_t          target_o
);

    word_t alu_out;
    logic  operands_eq;
    logic  taken;
    word_t result_q;
    word_t target_q;
    logic  taken_q;

    always_comb begin
        case (decoded_i.alu_op)
            ALU_SUB:    alu_out = decoded_i.op_a - decoded_i.op_b;
            ALU_AND:    alu_out = decoded_i.op_a & decoded_i.op_b;
            ALU_OR:     alu_out = decoded_i.op_a | decoded_i.op_b;
            ALU_XOR:    alu_out = decoded_i.op_a ^ decoded_i.op_b;
            ALU_SLT:    alu_out = word_t'($signed(decoded_i.op_a) < $signed(decoded_i.op_b));
            ALU_PASS_B: alu_out = decoded_i.op_b;
            default:    alu_out = decoded_i.op_a + decoded_i.op_b;
        endcase
    end

    // BEQ and BNE differ only in the sense of the compare
    assign operands_eq = (decoded_i.op_a == decoded_i.op_b);
    assign taken       = decoded_i.is_branch && (operands_eq ^ decoded_i.branch_ne);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            taken_q <= 1'b0;
        end else if (exec_load_i) begin
            taken_q <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_load_i) begin
            result_q <= alu_out;
            target_q <= decoded_i.pc + decoded_i.imm;
        end
    end

    assign alu_result_o   = result_q;
    assign branch_taken_o = taken_q;
    assign target_o       = target_q;

endmodule

//--- hdl/core_lsu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_lsu import core_isa_pkg::*, core_bus_pkg::*; (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           mem_req_i,
    input  decoded_instr_t decoded_i,
    input  word_t          alu_result_i,
    input  word_t          dmem_rdata_i,
    output dmem_req_t      dmem_req_o,
    output logic           dmem_req_valid_o,
    output word_t          load_data_o
);

    dmem_req_t req;

    // Effective address is word aligned, low bits dropped
    always_comb begin
        req.addr  = alu_result_i[`CORE_XLEN-1:2];
        req.wdata = decoded_i.store_data;
        req.we    = decoded_i.mem_write;
    end

    assign dmem_req_o       = req;
    assign dmem_req_valid_o = mem_req_i && (decoded_i.mem_read || decoded_i.mem_write);

    // Read data returns in the writeback cycle
    assign load_data_o = dmem_rdata_i;

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        dmem_req_valid_o |-> req.addr < `CORE_DMEM_WORDS);

endmodule

//--- hdl/core_writeback.sv
`timescale 1ns/1ps

module core_writeback import core_isa_pkg::*, core_bus_pkg::*; (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           wb_commit_i,
    input  decoded_instr_t decoded_i,
    input  word_t          instr_i,
    input  word_t          alu_result_i,
    input  word_t          load_data_i,
    output logic           rf_we_o,
    output reg_addr_t      rf_waddr_o,
    output word_t          rf_wdata_o,
    output retire_t        retire_o,
    output logic           retire_valid_o
);

    word_t   wb_value;
    retire_t retire_q;
    logic    retire_valid_q;

    always_comb begin
        case (decoded_i.wb_sel)
            WB_LOAD:     wb_value = load_data_i;
            WB_PC_PLUS4: wb_value = decoded_i.pc + 32'd4;
            default:     wb_value = alu_result_i;
        endcase
    end

    assign rf_we_o    = wb_commit_i && decoded_i.reg_write;
    assign rf_waddr_o = decoded_i.rd;
    assign rf_wdata_o = wb_value;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= wb_commit_i;
        end
    end

    // Record shows up one cycle after the commit
    always_ff @(posedge clk) begin
        if (wb_commit_i) begin
            retire_q.pc        <= decoded_i.pc;
            retire_q.instr     <= instr_i;
            retire_q.rd        <= decoded_i.rd;
            retire_q.rd_value  <= wb_value;
            retire_q.reg_write <= decoded_i.reg_write;
        end
    end

    assign retire_o       = retire_q;
    assign retire_valid_o = retire_valid_q;

endmodule

//--- hdl/core_top.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top import core_isa_pkg::*, core_bus_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    output imem_req_t imem_req_o,
    output logic      imem_req_valid_o,
    input  word_t     imem_rdata_i,
    output dmem_req_t dmem_req_o,
    output logic      dmem_req_valid_o,
    input  word_t     dmem_rdata_i,
    output retire_t   retire_o,
    output logic      retire_valid_o,
    output logic      halted_o
);

    // Sequencer strobes
    logic fetch_req;
    logic decode_load;
    logic exec_load;
    logic mem_req;
    logic wb_commit;

    decoded_instr_t decoded;
    word_t          instr;
    word_t          pc;
    reg_addr_t      rs1_addr;
    reg_addr_t      rs2_addr;
    word_t          rs1_data;
    word_t          rs2_data;
    word_t          alu_result;
    logic           branch_taken;
    word_t          target;
    word_t          load_data;
    logic           rf_we;
    reg_addr_t      rf_waddr;
    word_t          rf_wdata;

    core_ctrl ctrl_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .is_halt_i     (decoded.is_halt),
        .mem_read_i    (decoded.mem_read),
        .mem_write_i   (decoded.mem_write),
        .fetch_req_o   (fetch_req),
        .decode_load_o (decode_load),
        .exec_load_o   (exec_load),
        .mem_req_o     (mem_req),
        .wb_commit_o   (wb_commit),
        .halted_o      (halted_o)
    );

    core_fetch fetch_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .fetch_req_i      (fetch_req),
        .wb_commit_i      (wb_commit),
        .branch_taken_i   (branch_taken),
        .target_i         (target),
        .is_jal_i         (decoded.is_jal),
        .imem_req_o       (imem_req_o),
        .imem_req_valid_o (imem_req_valid_o),
        .pc_o             (pc)
    );

    core_decode decode_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .decode_load_i (decode_load),
        .imem_rdata_i  (imem_rdata_i),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .decoded_o     (decoded),
        .instr_o       (instr)
    );

    core_regfile #(
        .ADDR_WIDTH ($clog2(`CORE_NREGS)),
        .DATA_WIDTH (`CORE_XLEN)
    ) regfile_i (
        .clk      (clk),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    core_exec exec_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .exec_load_i    (exec_load),
        .decoded_i      (decoded),
        .alu_result_o   (alu_result),
        .branch_taken_o (branch_taken),
        .target_o       (target)
    );

    core_lsu lsu_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .mem_req_i        (mem_req),
        .decoded_i        (decoded),
        .alu_result_i     (alu_result),
        .dmem_rdata_i     (dmem_rdata_i),
        .dmem_req_o       (dmem_req_o),
        .dmem_req_valid_o (dmem_req_valid_o),
        .load_data_o      (load_data)
    );

    core_writeback writeback_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .wb_commit_i    (wb_commit),
        .decoded_i      (decoded),
        .instr_i        (instr),
        .alu_result_i   (alu_result),
        .load_data_i    (load_data),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o)
    );

endmodule

//--- verif/core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb import core_isa_pkg::*, core_bus_pkg::*;;

    localparam int    PROG_LEN       = 120;
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 5 + 50;
    localparam word_t EBREAK_WORD    = 32'h0010_0073;

    logic      clk;
    logic      reset_i;
    imem_req_t imem_req;
    logic      imem_req_valid;
    word_t     imem_rdata;
    dmem_req_t dmem_req;
    logic      dmem_req_valid;
    word_t     dmem_rdata;
    retire_t   retire;
    logic      retire_valid;
    logic      halted;

    // Memory models and their next read data
    word_t imem [`CORE_IMEM_WORDS];
    word_t dmem [`CORE_DMEM_WORDS];
    word_t imem_next;
    word_t dmem_next;

    // Reference model state
    word_t ref_regs [`CORE_NREGS];
    word_t ref_dmem [`CORE_DMEM_WORDS];
    word_t ref_pc;

    // Expected effects of the instruction in flight
    word_t      exp_instr;
    logic [4:0] exp_rd;
    word_t      exp_val;
    logic       exp_write;
    logic       exp_mem;
    logic       exp_mwe;
    word_t      exp_maddr;
    word_t      exp_mwdata;
    word_t      exp_next;
    logic       exp_halt;

    logic        pending;
    logic        mem_seen;
    logic        halt_seen;
    int          cycle;
    int          fetch_cycle;
    int          halt_cycle;
    logic [31:0] lfsr_q;

    core_top core_top_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .imem_req_o       (imem_req),
        .imem_req_valid_o (imem_req_valid),
        .imem_rdata_i     (imem_rdata),
        .dmem_req_o       (dmem_req),
        .dmem_req_valid_o (dmem_req_valid),
        .dmem_rdata_i     (dmem_rdata),
        .retire_o         (retire),
        .retire_valid_o   (retire_valid),
        .halted_o         (halted)
    );

    always #50 clk = ~clk;

    task automatic fail_value(input string sig, input word_t exp, input word_t act);
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, sig, exp, act);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("[ERROR] %0t ns: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string sig, input word_t exp, input word_t act);
        assert (act === exp) else fail_value(sig, exp, act);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] alu_funct3(input logic [2:0] pick);
        case (pick)
            3'd2:       return 3'b111;
            3'd3:       return 3'b110;
            3'd4:       return 3'b100;
            3'd5, 3'd6: return 3'b010;
            default:    return 3'b000;
        endcase
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // First seven slots give x1..x7 known values, the rest is random
    task automatic build_program();
        int         skip;
        logic [2:0] kind;
        logic [2:0] pick;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int i = 0; i < `CORE_IMEM_WORDS; i++) begin
            if (i >= PROG_LEN - 1) begin
                imem[i] = EBREAK_WORD;
            end else if (i < 7) begin
                imem[i] = enc_i(12'(take_bits(12)), 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM);
            end else begin
                rd   = 5'(take_bits(3));
                rs1  = 5'(take_bits(3));
                rs2  = 5'(take_bits(3));
                pick = 3'(take_bits(3));
                skip = 1 + int'(take_bits(2)) % 3;
                // Never jump past the final EBREAK
                if (i + 1 + skip > PROG_LEN - 1) begin
                    skip = PROG_LEN - 2 - i;
                end
                kind = 3'(take_bits(3));
                case (kind)
                    3'd0, 3'd1: imem[i] = enc_r((pick == 3'd1 || pick == 3'd7) ? 7'h20 : 7'h00,
                                                rs2, rs1, alu_funct3(pick), rd);
                    3'd2: imem[i] = enc_i(12'(take_bits(12)), rs1, alu_funct3(pick), rd,
                                          OPC_OP_IMM);
                    3'd3: imem[i] = {20'(take_bits(20)), rd, OPC_LUI};
                    3'd4: imem[i] = enc_i({4'b0, 6'(take_bits(6)), 2'b00}, 5'd0, 3'b010, rd,
                                          OPC_LOAD);
                    3'd5: imem[i] = enc_s({4'b0, 6'(take_bits(6)), 2'b00}, rs2, 5'd0);
                    3'd6: imem[i] = enc_b(13'((skip + 1) * 4), rs2, rs1, {2'b00, pick[0]});
                    default: imem[i] = enc_j(21'((skip + 1) * 4), rd);
                endcase
            end
        end
    endtask

    // ISA rules applied to the reference state
    task automatic predict(input word_t ins);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        opc        = ins[6:0];
        f3         = ins[14:12];
        a          = ref_regs[ins[19:15]];
        b          = ref_regs[ins[24:20]];
        imm_i      = {{20{ins[31]}}, ins[31:20]};
        imm_s      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b      = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j      = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp_instr  = ins;
        exp_rd     = ins[11:7];
        exp_val    = '0;
        exp_write  = 1'b0;
        exp_mem    = 1'b0;
        exp_mwe    = 1'b0;
        exp_maddr  = '0;
        exp_mwdata = '0;
        exp_next   = ref_pc + 32'd4;
        exp_halt   = 1'b0;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                exp_write = 1'b1;
                if (opc == OPC_OP_IMM) begin
                    b = imm_i;
                end
                case (f3)
                    3'b000:  exp_val = (opc == OPC_OP && ins[30]) ? a - b : a + b;
                    3'b010:  exp_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  exp_val = a ^ b;
                    3'b110:  exp_val = a | b;
                    default: exp_val = a & b;
                endcase
            end
            OPC_LUI: begin
                exp_write = 1'b1;
                exp_val   = {ins[31:12], 12'b0};
            end
            OPC_LOAD: begin
                exp_write = 1'b1;
                exp_mem   = 1'b1;
                exp_maddr = (a + imm_i) >> 2;
                exp_val   = ref_dmem[exp_maddr % `CORE_DMEM_WORDS];
            end
            OPC_STORE: begin
                exp_mem    = 1'b1;
                exp_mwe    = 1'b1;
                exp_maddr  = (a + imm_s) >> 2;
                exp_mwdata = b;
            end
            OPC_BRANCH: begin
                // funct3 bit 0 selects BNE
                if ((a == b) != f3[0]) begin
                    exp_next = ref_pc + imm_b;
                end
            end
            OPC_JAL: begin
                exp_write = 1'b1;
                exp_val   = ref_pc + 32'd4;
                exp_next  = ref_pc + imm_j;
            end
            default: exp_halt = 1'b1;
        endcase
        if (exp_rd == 5'd0) begin
            exp_write = 1'b0;
        end
    endtask

    task automatic handle_fetch();
        assert (!pending && !halt_seen)
            else fail_plain("fetch request while an instruction is in flight or after halt");
        check_word("imem_req_o.addr", ref_pc >> 2, imem_req.addr);
        imem_next   = imem[imem_req.addr % `CORE_IMEM_WORDS];
        predict(imem_next);
        pending     = 1'b1;
        mem_seen    = 1'b0;
        fetch_cycle = cycle;
    endtask

    task automatic handle_dmem();
        assert (pending && exp_mem && !mem_seen)
            else fail_plain("data memory request that the instruction does not make");
        check_word("dmem_req_o.addr", exp_maddr, dmem_req.addr);
        check_word("dmem_req_o.we", exp_mwe, dmem_req.we);
        if (exp_mwe) begin
            check_word("dmem_req_o.wdata", exp_mwdata, dmem_req.wdata);
            dmem[dmem_req.addr % `CORE_DMEM_WORDS] = dmem_req.wdata;
        end
        dmem_next = dmem[dmem_req.addr % `CORE_DMEM_WORDS];
        mem_seen  = 1'b1;
    endtask

    task automatic handle_retire();
        assert (pending) else fail_plain("retire strobe without a fetched instruction");
        check_word("retire_o.pc", ref_pc, retire.pc);
        check_word("retire_o.instr", exp_instr, retire.instr);
        check_word("retire_o.rd", exp_rd, retire.rd);
        check_word("retire_o.reg_write", exp_write, retire.reg_write);
        if (exp_write) begin
            check_word("retire_o.rd_value", exp_val, retire.rd_value);
        end
        assert (mem_seen == exp_mem) else fail_plain("load or store retired without its request");
        check_word("fetch to retire cycles", exp_mem ? 5 : 4, cycle - fetch_cycle);
        // Commit to the reference state
        if (exp_write) begin
            ref_regs[exp_rd] = exp_val;
        end
        if (exp_mwe) begin
            ref_dmem[exp_maddr % `CORE_DMEM_WORDS] = exp_mwdata;
        end
        ref_pc  = exp_next;
        pending = 1'b0;
        if (exp_halt) begin
            halt_seen  = 1'b1;
            halt_cycle = cycle;
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        imem_next  = '0;
        dmem_next  = '0;
        pending    = 1'b0;
        mem_seen   = 1'b0;
        halt_seen  = 1'b0;
        cycle      = 0;
        halt_cycle = 0;
        ref_pc     = `CORE_RESET_PC;
        lfsr_q     = 32'hc176a479;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            ref_regs[r] = '0;
        end
        for (int w = 0; w < `CORE_DMEM_WORDS; w++) begin
            dmem[w]     = 32'h9e37_79b9 * (w + 1);
            ref_dmem[w] = dmem[w];
        end
        build_program();
        repeat (2) @(posedge clk);
        #1 reset_i = 1'b0;
    end

    // Memory read data one cycle after the request
    always @(posedge clk) begin
        #1;
        imem_rdata = imem_next;
        dmem_rdata = dmem_next;
    end

    // Outputs are sampled mid cycle
    always @(negedge clk) begin
        if (reset_i) begin
            check_word("retire_valid_o", 0, retire_valid);
            check_word("dmem_req_valid_o", 0, dmem_req_valid);
            check_word("halted_o", 0, halted);
        end else begin
            cycle++;
            assert (cycle <= TIMEOUT_CYCLES) else fail_plain("timeout, the core never halted");
            if (cycle == 1) begin
                assert (imem_req_valid) else fail_plain("no fetch in the first cycle after reset");
            end
            check_word("halted_o", halt_seen && cycle > halt_cycle, halted);
            if (retire_valid) begin
                handle_retire();
            end
            if (dmem_req_valid) begin
                handle_dmem();
            end
            if (imem_req_valid) begin
                handle_fetch();
            end
            if (halt_seen && cycle == halt_cycle + 4) begin
                $display("*** PASSED ***");
                $finish;
            end
        end
    end

    a_no_fetch_halted: assert property (@(posedge clk) disable iff (reset_i)
        halted |-> !imem_req_valid) else fail_plain("fetch request while halted");

endmodule

//--- src.f
+incdir+hdl
hdl/core_isa_pkg.sv
hdl/core_bus_pkg.sv
hdl/core_ctrl.sv
hdl/core_fetch.sv
hdl/core_decode.sv
hdl/core_regfile.sv
hdl/core_exec.sv
hdl/core_lsu.sv
hdl/core_writeback.sv
hdl/core_top.sv
verif/core_tb.sv
